//--- hw/sdram_params.svh
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// geometry of the x16 part
`define SDRAM_DATA_W    16
`define SDRAM_BYTES     2     // byte lanes on dq
`define SDRAM_BA_W      2     // 4 banks
`define SDRAM_ROW_W     12    // 4096 rows
`define SDRAM_COL_W     8     // 256 columns
`define SDRAM_ADDR_W    12    // a11..a0 pins
`define SDRAM_HADDR_W   22    // bank + row + col
`define SDRAM_AP_BIT    10    // all-bank / auto-precharge select

// read latency programmed into the mode register
`define SDRAM_CAS       3

// timing in clock cycles at 100 MHz
`define SDRAM_INIT_CYC  20001 // 200 us power-on wait
`define SDRAM_RP_CYC    2     // precharge period
`define SDRAM_RCD_CYC   2     // activate to read or write
`define SDRAM_RAS_CYC   4     // activate to precharge
`define SDRAM_RFC_CYC   7     // auto-refresh period
`define SDRAM_WR_CYC    2     // write recovery
`define SDRAM_MODE_CYC  2     // mode register set
`define SDRAM_REF_CYC   1563  // 64 ms spread over 4096 rows
`define SDRAM_INIT_RFSH 8     // refreshes before mode set

`endif

//--- hw/sdram_pkg.sv
`include "sdram_params.svh"

package sdram_pkg;

  // command pins {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    NOP       = 4'b0111,
    ACTIVE    = 4'b0011,
    READ      = 4'b0101,
    WRITE     = 4'b0100,
    PRECHARGE = 4'b0010,
    MODE      = 4'b0000,
    REFRESH   = 4'b0001
  } cmd_e;

  typedef enum logic [2:0] {
    INIT_WAIT,   // power-on interval, cke low
    INIT_PCHG,   // precharge all after power-on
    INIT_RFSH,   // the eight init refreshes
    SET_MODE,    // load mode register
    IDLE_RW,     // arbitrate refresh, read, write
    ACTIVATE,    // open the requested row
    REFRESH_ROW  // periodic auto-refresh
  } state_e;

  // host address map is bank, row, col
  typedef struct packed {
    logic [`SDRAM_BA_W-1:0]  bank;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_COL_W-1:0] col;
  } host_addr_t;

  // mode register layout on a11..a0
  typedef struct packed {
    logic [1:0] rsvd;        // a11..a10
    logic       wb_mode;     // a9
    logic [1:0] op_mode;     // a8..a7, 0 for standard operation
    logic [2:0] cas_lat;     // a6..a4
    logic       burst_type;  // a3, 0 sequential
    logic [2:0] burst_len;   // a2..a0, 0 means one word
  } mode_word_t;

  // read/write/precharge layout
  typedef struct packed {
    logic [`SDRAM_ADDR_W-`SDRAM_AP_BIT-2:0] upper;  // a11
    logic                                   ap;     // a10
    logic [`SDRAM_AP_BIT-1:0]               col;    // a9..a0
  } col_word_t;

  typedef union packed {
    mode_word_t mode;
    col_word_t  col;
  } sdram_addr_u;

endpackage

//--- hw/sdram_ifs.sv
`include "sdram_params.svh"

// FSM to open-row table
interface bank_if;
  logic [`SDRAM_BA_W-1:0]  bank;        // bank of pending request
  logic [`SDRAM_ROW_W-1:0] row;         // row of pending request
  logic                    open_row;    // activate issued
  logic                    close_bank;  // single-bank precharge issued
  logic                    close_all;   // all-bank precharge issued
  logic                    row_hit;     // bank open on this row

  modport fsm (
    output bank, row, open_row, close_bank, close_all,
    input  row_hit
  );

  modport tbl (
    input  bank, row, open_row, close_bank, close_all,
    output row_hit
  );
endinterface

// FSM to the timing counters
interface timer_if;
  logic start_ras;       // activate issued
  logic start_wr;        // write issued
  logic load_init_rfsh;  // preset pending count for init
  logic take_rfsh;       // refresh issued
  logic row_busy;        // tRAS still running
  logic wr_busy;         // write recovery still running
  logic rfsh_due;        // at least one refresh owed
  logic rfsh_last;       // exactly one owed

  modport fsm (
    output start_ras, start_wr, load_init_rfsh, take_rfsh,
    input  row_busy, wr_busy, rfsh_due, rfsh_last
  );

  modport timers (
    input  start_ras, start_wr, load_init_rfsh, take_rfsh,
    output row_busy, wr_busy, rfsh_due, rfsh_last
  );
endinterface

//--- hw/sdram_bank_table.sv
`include "sdram_params.svh"

module sdram_bank_table (
  input logic clk,
  input logic rst,
  bank_if.tbl bk
);

  localparam int NBANK = 1 << `SDRAM_BA_W;

  logic [NBANK-1:0]        open_q;         // some row open in bank
  logic [`SDRAM_ROW_W-1:0] row_q [NBANK];  // the open row per bank

  ////////////////////////////////////////////////////////////
  // open flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      open_q <= '0;  // nothing open after power-up
    end else if (bk.close_all) begin
      open_q <= '0;  // refresh precharges every bank
    end else if (bk.close_bank) begin
      open_q[bk.bank] <= 1'b0;
    end else if (bk.open_row) begin
      open_q[bk.bank] <= 1'b1;
    end
  end

  // row number only matters while the flag is set
  always_ff @(posedge clk) begin
    if (bk.open_row) begin
      row_q[bk.bank] <= bk.row;
    end
  end

  ////////////////////////////////////////////////////////////
  // hit test on the pending request
  ////////////////////////////////////////////////////////////

  // miss if bank closed or another row open there
  assign bk.row_hit = open_q[bk.bank] && (row_q[bk.bank] == bk.row);

endmodule

//--- hw/sdram_timers.sv
`include "sdram_params.svh"

module sdram_timers (
  input logic     clk,
  input logic     rst,
  timer_if.timers tm
);

  localparam int RAS_W  = $clog2(`SDRAM_RAS_CYC + 1);
  localparam int WR_W   = $clog2(`SDRAM_WR_CYC + 1);
  localparam int REF_W  = $clog2(`SDRAM_REF_CYC + 1);
  localparam int PEND_W = `SDRAM_ROW_W;  // room for a long backlog

  logic [RAS_W-1:0]  ras_q;   // activate to precharge
  logic [WR_W-1:0]   wr_q;    // write to precharge
  logic [REF_W-1:0]  ref_q;   // interval between row refreshes
  logic [PEND_W-1:0] pend_q;  // refreshes owed
  logic              ref_tick;

  assign ref_tick = (ref_q == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ras_q  <= '0;
      wr_q   <= '0;
      ref_q  <= REF_W'(`SDRAM_REF_CYC - 1);
      pend_q <= '0;
    end else begin
      if (tm.start_ras) ras_q <= RAS_W'(`SDRAM_RAS_CYC);
      else if (ras_q != '0) ras_q <= ras_q - 1'b1;

      if (tm.start_wr) wr_q <= WR_W'(`SDRAM_WR_CYC);
      else if (wr_q != '0) wr_q <= wr_q - 1'b1;

      // free running, one tick every REF_CYC cycles
      ref_q <= ref_tick ? REF_W'(`SDRAM_REF_CYC - 1) : ref_q - 1'b1;

      if (tm.load_init_rfsh) begin
        pend_q <= PEND_W'(`SDRAM_INIT_RFSH);  // init sequence overrides backlog
      end else begin
        case ({ref_tick, tm.take_rfsh})
          2'b10:   pend_q <= pend_q + 1'b1;
          2'b01:   pend_q <= pend_q - 1'b1;
          default: pend_q <= pend_q;  // both or neither cancel out
        endcase
      end
    end
  end

  assign tm.row_busy  = (ras_q != '0);
  assign tm.wr_busy   = (wr_q != '0);
  assign tm.rfsh_due  = (pend_q != '0);
  assign tm.rfsh_last = (pend_q == PEND_W'(1));  // init loop ends here

endmodule

//--- hw/sdram_cmd_fsm.sv
`include "sdram_params.svh"

module sdram_cmd_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rd,
  input  logic                      wr,
  input  logic [`SDRAM_HADDR_W-1:0] addr,
  input  logic [`SDRAM_DATA_W-1:0]  wdata,
  input  logic [`SDRAM_BYTES-1:0]   be,
  output logic                      op_begun,
  output logic                      cke,
  output sdram_pkg::cmd_e           cmd,
  output logic [`SDRAM_BA_W-1:0]    ba,
  output logic [`SDRAM_ADDR_W-1:0]  sa,
  output logic [`SDRAM_BYTES-1:0]   dqm,
  output logic [`SDRAM_DATA_W-1:0]  dq_out,
  output logic                      issue_rd,
  output logic                      issue_wr,
  input  logic                      rd_busy,
  bank_if.fsm                       bk,
  timer_if.fsm                      tm
);

  localparam int TMR_W = $clog2(`SDRAM_INIT_CYC + 1);  // sized for the power-on wait

  sdram_pkg::host_addr_t   req;
  sdram_pkg::state_e       state_q, state_d;
  logic [TMR_W-1:0]        timer_q, timer_d;  // main sequencing wait
  sdram_pkg::cmd_e         cmd_d;
  sdram_pkg::sdram_addr_u  sa_d;
  logic [`SDRAM_BA_W-1:0]  ba_d;
  logic [`SDRAM_BYTES-1:0] dqm_d;
  logic                    cke_d;
  logic                    rd_last_q;  // READ on the pins now
  logic                    quiet;      // safe to precharge

  assign req      = addr;  // bank, row, col
  assign bk.bank  = req.bank;
  assign bk.row   = req.row;
  assign quiet    = !tm.row_busy && !tm.wr_busy && !rd_busy;
  assign cke_d    = (state_q != sdram_pkg::INIT_WAIT) || (timer_q == '0);

  ////////////////////////////////////////////////////////////
  // next state and command
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    timer_d   = timer_q;
    cmd_d     = sdram_pkg::NOP;
    ba_d      = req.bank;              // bank pins follow the request
    dqm_d     = rd_last_q ? '0 : '1;   // dqm latency 2 covers CAS 3 data
    sa_d      = '0;
    sa_d.col.col[`SDRAM_COL_W-1:0] = req.col;
    op_begun  = 1'b0;
    issue_rd  = 1'b0;
    issue_wr  = 1'b0;
    bk.open_row       = 1'b0;
    bk.close_bank     = 1'b0;
    bk.close_all      = 1'b0;
    tm.start_ras      = 1'b0;
    tm.start_wr       = 1'b0;
    tm.load_init_rfsh = 1'b0;
    tm.take_rfsh      = 1'b0;

    if (timer_q != '0) begin
      timer_d = timer_q - 1'b1;  // previous command still settling
    end else begin
      case (state_q)
        sdram_pkg::INIT_WAIT: state_d = sdram_pkg::INIT_PCHG;  // cke rises here
        sdram_pkg::INIT_PCHG: begin
          cmd_d             = sdram_pkg::PRECHARGE;
          sa_d.col.ap       = 1'b1;  // all banks
          timer_d           = TMR_W'(`SDRAM_RP_CYC);
          tm.load_init_rfsh = 1'b1;
          state_d           = sdram_pkg::INIT_RFSH;
        end
        sdram_pkg::INIT_RFSH: begin
          cmd_d        = sdram_pkg::REFRESH;
          timer_d      = TMR_W'(`SDRAM_RFC_CYC);
          tm.take_rfsh = 1'b1;
          if (tm.rfsh_last) state_d = sdram_pkg::SET_MODE;
        end
        sdram_pkg::SET_MODE: begin
          cmd_d             = sdram_pkg::MODE;
          ba_d              = '0;  // base mode register
          sa_d              = '0;
          sa_d.mode.cas_lat = 3'(`SDRAM_CAS);  // burst length 1, sequential
          timer_d           = TMR_W'(`SDRAM_MODE_CYC);
          state_d           = sdram_pkg::IDLE_RW;
        end
        sdram_pkg::IDLE_RW: begin
          if (tm.rfsh_due) begin
            // refresh first, once nothing is in flight
            if (quiet) begin
              cmd_d        = sdram_pkg::PRECHARGE;
              sa_d.col.ap  = 1'b1;
              timer_d      = TMR_W'(`SDRAM_RP_CYC);
              bk.close_all = 1'b1;
              state_d      = sdram_pkg::REFRESH_ROW;
            end
          end else if ((rd || wr) && (req.bank == ba)) begin  // one cycle on bank change
            if (!bk.row_hit) begin
              if (quiet) begin
                cmd_d         = sdram_pkg::PRECHARGE;  // a10 low, this bank only
                timer_d       = TMR_W'(`SDRAM_RP_CYC);
                bk.close_bank = 1'b1;
                state_d       = sdram_pkg::ACTIVATE;
              end
            end else if (rd) begin
              cmd_d    = sdram_pkg::READ;  // pipelined behind earlier reads
              dqm_d    = '0;
              op_begun = 1'b1;
              issue_rd = 1'b1;
            end else if (!rd_busy) begin
              cmd_d       = sdram_pkg::WRITE;
              dqm_d       = ~be;  // mask the lanes not written
              op_begun    = 1'b1;
              issue_wr    = 1'b1;
              tm.start_wr = 1'b1;
            end
          end
        end
        sdram_pkg::ACTIVATE: begin
          cmd_d        = sdram_pkg::ACTIVE;
          sa_d         = req.row;
          bk.open_row  = 1'b1;
          tm.start_ras = 1'b1;
          timer_d      = TMR_W'(`SDRAM_RCD_CYC);
          state_d      = sdram_pkg::IDLE_RW;  // back to retry the access
        end
        sdram_pkg::REFRESH_ROW: begin
          cmd_d        = sdram_pkg::REFRESH;
          timer_d      = TMR_W'(`SDRAM_RFC_CYC);
          tm.take_rfsh = 1'b1;
          state_d      = sdram_pkg::IDLE_RW;
        end
        default: state_d = sdram_pkg::INIT_WAIT;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // registered pins
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= sdram_pkg::INIT_WAIT;
      timer_q   <= TMR_W'(`SDRAM_INIT_CYC);  // power-on interval starts at reset
      cke       <= 1'b0;
      cmd       <= sdram_pkg::NOP;
      dqm       <= '1;
      ba        <= '0;
      rd_last_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      timer_q   <= timer_d;
      cke       <= cke_d;
      cmd       <= cmd_d;
      dqm       <= dqm_d;
      ba        <= ba_d;
      rd_last_q <= issue_rd;
    end
  end

  always_ff @(posedge clk) begin
    sa     <= sa_d;
    dq_out <= wdata;  // only sampled with WRITE
  end

endmodule

//--- hw/sdram_read_pipe.sv
`include "sdram_params.svh"

module sdram_read_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_rd,
  input  logic                     issue_wr,
  input  logic [`SDRAM_DATA_W-1:0] dq_in,
  output logic                     rd_busy,
  output logic                     done,
  output logic                     rd_done,
  output logic                     rd_pending,
  output logic [`SDRAM_DATA_W-1:0] rdata
);

  localparam int DEPTH = `SDRAM_CAS + 2;  // command cycle + latency + host stage

  logic [DEPTH-1:0] rd_q;    // read flags shift toward bit 0
  logic             wr_q;    // write done one cycle after accept
  logic             in_flight;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_q <= '0;
      wr_q <= 1'b0;
    end else begin
      rd_q <= {issue_rd, rd_q[DEPTH-1:1]};  // new read enters at the top
      wr_q <= issue_wr;
    end
  end

  // dq valid while the flag sits at stage 1
  always_ff @(posedge clk) begin
    if (rd_q[1]) rdata <= dq_in;
  end

  assign in_flight  = |rd_q[DEPTH-1:1];
  assign rd_busy    = in_flight;   // holds off writes and precharge
  assign rd_pending = in_flight;
  assign rd_done    = rd_q[0];     // rdata already loaded
  assign done       = rd_q[0] | wr_q;

endmodule

//--- hw/sdram_ctrl.sv
`include "sdram_params.svh"

module sdram_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  // host side
  input  logic                      rd,
  input  logic                      wr,
  input  logic [`SDRAM_HADDR_W-1:0] addr,
  input  logic [`SDRAM_DATA_W-1:0]  wdata,
  input  logic [`SDRAM_BYTES-1:0]   be,
  output logic                      op_begun,
  output logic                      done,
  output logic                      rd_done,
  output logic                      rd_pending,
  output logic [`SDRAM_DATA_W-1:0]  rdata,
  // sdram pins
  output logic                      cke,
  output logic                      cs_n,
  output logic                      ras_n,
  output logic                      cas_n,
  output logic                      we_n,
  output logic [`SDRAM_BA_W-1:0]    ba,
  output logic [`SDRAM_ADDR_W-1:0]  sa,
  output logic [`SDRAM_BYTES-1:0]   dqm,
  output logic [`SDRAM_DATA_W-1:0]  dq_out,
  input  logic [`SDRAM_DATA_W-1:0]  dq_in
);

  bank_if  bk_if ();
  timer_if tm_if ();

  sdram_pkg::cmd_e cmd;
  logic            issue_rd;  // READ accepted this cycle
  logic            issue_wr;  // WRITE accepted this cycle
  logic            rd_busy;

  assign {cs_n, ras_n, cas_n, we_n} = cmd;  // command onto its four pins

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  sdram_bank_table u_bank_table (.clk(clk), .rst(rst), .bk(bk_if.tbl));

  sdram_timers u_timers (.clk(clk), .rst(rst), .tm(tm_if.timers));

  sdram_cmd_fsm u_cmd_fsm (
    .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .be(be),
    .op_begun(op_begun), .cke(cke), .cmd(cmd), .ba(ba), .sa(sa), .dqm(dqm),
    .dq_out(dq_out), .issue_rd(issue_rd), .issue_wr(issue_wr), .rd_busy(rd_busy),
    .bk(bk_if.fsm), .tm(tm_if.fsm)
  );

  sdram_read_pipe u_read_pipe (
    .clk(clk), .rst(rst), .issue_rd(issue_rd), .issue_wr(issue_wr), .dq_in(dq_in),
    .rd_busy(rd_busy), .done(done), .rd_done(rd_done), .rd_pending(rd_pending),
    .rdata(rdata)
  );

endmodule

//--- test/sdram_model.sv
`include "sdram_params.svh"

module sdram_model (
  input  logic                     clk,
  input  logic                     cke,
  input  logic                     cs_n,
  input  logic                     ras_n,
  input  logic                     cas_n,
  input  logic                     we_n,
  input  logic [`SDRAM_BA_W-1:0]   ba,
  input  logic [`SDRAM_ADDR_W-1:0] sa,
  input  logic [`SDRAM_BYTES-1:0]  dqm,
  input  logic [`SDRAM_DATA_W-1:0] wdq,       // data driven by the controller
  output logic [`SDRAM_DATA_W-1:0] rdq,       // data back to the controller
  output logic                     mode_seen,
  output logic [2:0]               mode_cas,
  output logic [2:0]               mode_bl,
  output logic [31:0]              rfsh_cnt,  // every REFRESH since power-up
  output logic                     proto_err  // sticky
);

  localparam int KEY_W = `SDRAM_BA_W + `SDRAM_ROW_W + `SDRAM_COL_W;
  localparam int NBANK = 1 << `SDRAM_BA_W;

  logic [`SDRAM_DATA_W-1:0] mem [logic [KEY_W-1:0]];  // sparse, only written words
  logic [`SDRAM_ROW_W-1:0]  row_q [NBANK];
  logic [NBANK-1:0]         open_q = '0;
  logic [`SDRAM_CAS:1][`SDRAM_DATA_W-1:0] dpipe = '0;  // read data toward the pins
  logic [1:0]               phase = 2'd0;  // 0 power-up, 1 init refreshes, 2 running
  logic                     pall_q = 1'b0; // last command was precharge all
  int                       init_n = 0;
  sdram_pkg::cmd_e          cmd;
  sdram_pkg::sdram_addr_u   a;
  logic [KEY_W-1:0]         key;

  // unwritten words read back as a pattern of the full address
  function automatic logic [`SDRAM_DATA_W-1:0] fill_word(input logic [KEY_W-1:0] k);
    return 16'(k ^ (k >> 6));
  endfunction

  assign cmd       = sdram_pkg::cmd_e'({cs_n, ras_n, cas_n, we_n});
  assign a         = sa;
  assign key       = {ba, row_q[ba], a.col.col[`SDRAM_COL_W-1:0]};  // open row of that bank
  assign rdq       = dpipe[`SDRAM_CAS];
  assign mode_seen = (phase == 2'd2);

  initial begin
    rfsh_cnt  = '0;
    proto_err = 1'b0;
    mode_cas  = '0;
    mode_bl   = '0;
  end

  ////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [`SDRAM_DATA_W-1:0] word;
    logic [`SDRAM_DATA_W-1:0] rword;
    int b;
    rword = '0;
    word  = mem.exists(key) ? mem[key] : fill_word(key);
    if (cke) begin
      case (cmd)
        sdram_pkg::PRECHARGE: begin
          if (a.col.ap) open_q <= '0;
          else open_q[ba] <= 1'b0;
          pall_q <= a.col.ap;
          if (phase == 2'd0 && a.col.ap) phase <= 2'd1;  // init sequence begins
        end
        sdram_pkg::REFRESH: begin
          if (phase == 2'd0 || (phase == 2'd2 && !pall_q)) proto_err <= 1'b1;
          if (phase == 2'd1) init_n <= init_n + 1;
          rfsh_cnt <= rfsh_cnt + 1;
          pall_q   <= 1'b0;
        end
        sdram_pkg::MODE: begin
          // exactly the init refreshes, then the mode word
          if (phase != 2'd1 || init_n != `SDRAM_INIT_RFSH) proto_err <= 1'b1;
          phase    <= 2'd2;
          mode_cas <= a.mode.cas_lat;
          mode_bl  <= a.mode.burst_len;
          pall_q   <= 1'b0;
        end
        sdram_pkg::ACTIVE: begin
          if (phase != 2'd2) proto_err <= 1'b1;
          open_q[ba] <= 1'b1;
          row_q[ba]  <= sa;
          pall_q     <= 1'b0;
        end
        sdram_pkg::READ: begin
          if (phase != 2'd2 || !open_q[ba]) proto_err <= 1'b1;  // closed bank
          rword  = word;
          pall_q <= 1'b0;
        end
        sdram_pkg::WRITE: begin
          if (phase != 2'd2 || !open_q[ba]) proto_err <= 1'b1;
          for (b = 0; b < `SDRAM_BYTES; b++) begin
            if (!dqm[b]) word[8*b +: 8] = wdq[8*b +: 8];  // dqm high masks the lane
          end
          mem[key] = word;
          pall_q   <= 1'b0;
        end
        default: ;
      endcase
    end
    dpipe <= {dpipe[`SDRAM_CAS-1:1], rword};  // CAS latency stages
  end

endmodule

//--- test/sdram_ctrl_checker.sv
`include "sdram_params.svh"

module sdram_ctrl_checker (
  input logic clk,
  input logic rst,
  input logic cke,
  input logic cs_n,
  input logic ras_n,
  input logic cas_n,
  input logic we_n
);

  localparam int AGE_MAX = 255;

  sdram_pkg::cmd_e cmd;
  int              act_age;  // cycles since last ACTIVE
  int              rf_age;   // cycles since last REFRESH
  logic            mode_q;   // mode register loaded

  assign cmd = sdram_pkg::cmd_e'({cs_n, ras_n, cas_n, we_n});

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      act_age <= AGE_MAX;
      rf_age  <= AGE_MAX;
      mode_q  <= 1'b0;
    end else begin
      if (cmd == sdram_pkg::ACTIVE) act_age <= 1;
      else if (act_age < AGE_MAX) act_age <= act_age + 1;
      if (cmd == sdram_pkg::REFRESH) rf_age <= 1;
      else if (rf_age < AGE_MAX) rf_age <= rf_age + 1;
      if (cmd == sdram_pkg::MODE) mode_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // protocol rules
  ////////////////////////////////////////////////////////////

  // tRCD between row open and column access
  assert property (@(posedge clk) disable iff (rst)
    (cmd == sdram_pkg::READ || cmd == sdram_pkg::WRITE) |-> act_age > `SDRAM_RCD_CYC)
    else $error("column command too soon after ACTIVE");

  assert property (@(posedge clk) disable iff (rst) mode_q |-> cke)
    else $error("cke dropped after mode register set");

  // tRFC before the next row open
  assert property (@(posedge clk) disable iff (rst)
    (cmd == sdram_pkg::ACTIVE) |-> rf_age > `SDRAM_RFC_CYC)
    else $error("ACTIVE inside the refresh period");

endmodule

//--- test/sdram_ctrl_tb.sv
`include "sdram_params.svh"

module sdram_ctrl_tb;

  localparam int          NADDR = 32;   // address pool where pairs share a row
  localparam int          NOPS  = 200;  // random operations
  localparam logic [31:0] SEED  = 32'h203d4826;

  logic                      clk = 1'b0;
  logic                      rst, rd, wr;
  logic [`SDRAM_HADDR_W-1:0] addr;
  logic [`SDRAM_DATA_W-1:0]  wdata, rdata, dq_out, dq_in;
  logic [`SDRAM_BYTES-1:0]   be, dqm;
  logic                      op_begun, done, rd_done, rd_pending;
  logic                      cke, cs_n, ras_n, cas_n, we_n;
  logic [`SDRAM_BA_W-1:0]    ba;
  logic [`SDRAM_ADDR_W-1:0]  sa;
  logic                      mode_seen, proto_err;
  logic [2:0]                mode_cas, mode_bl;
  logic [31:0]               rfsh_cnt, seed;

  logic [`SDRAM_HADDR_W-1:0] pool_addr [NADDR];
  logic [`SDRAM_DATA_W-1:0]  shadow [NADDR];  // expected contents
  logic [`SDRAM_DATA_W-1:0]  exp_q [$];       // read data in accept order
  int                        due_q [$];       // cycle at which done must be seen
  int                        cyc = 0;
  int                        inflight = 0;    // reads accepted, no rd_done yet

  always #2 clk = ~clk;

  sdram_ctrl u_dut (
    .clk(clk), .rst(rst), .rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .be(be),
    .op_begun(op_begun), .done(done), .rd_done(rd_done), .rd_pending(rd_pending),
    .rdata(rdata), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
    .ba(ba), .sa(sa), .dqm(dqm), .dq_out(dq_out), .dq_in(dq_in)
  );

  sdram_model u_mem (
    .clk(clk), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
    .ba(ba), .sa(sa), .dqm(dqm), .wdq(dq_out), .rdq(dq_in), .mode_seen(mode_seen),
    .mode_cas(mode_cas), .mode_bl(mode_bl), .rfsh_cnt(rfsh_cnt), .proto_err(proto_err)
  );

  bind sdram_ctrl sdram_ctrl_checker u_checker (
    .clk(clk), .rst(rst), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bytes with be set take the new data, the rest keep the old word
  function automatic logic [15:0] ref_word(input logic [15:0] old, input logic [15:0] d,
                                           input logic [1:0] m);
    logic [15:0] r;
    r = old;
    if (m[0]) r[7:0] = d[7:0];
    if (m[1]) r[15:8] = d[15:8];
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // hold the request until op_begun, then book the expected results
  task automatic issue(input logic is_wr, input int idx, input logic [15:0] d,
                       input logic [1:0] m);
    int n;
    rd    <= !is_wr;
    wr    <= is_wr;
    addr  <= pool_addr[idx];
    wdata <= d;
    be    <= m;
    n = 0;
    @(posedge clk);
    while (op_begun !== 1'b1) begin
      if (n > 200) fail_run("request was never accepted");
      n++;
      @(posedge clk);
    end
    if (is_wr) begin
      shadow[idx] = ref_word(shadow[idx], d, m);
      due_q.push_back(cyc + 1);  // done right after the WRITE command
    end else begin
      exp_q.push_back(shadow[idx]);
      due_q.push_back(cyc + `SDRAM_CAS + 2);  // rd_done sampled one edge after it rises
    end
  endtask

  task automatic idle_bus();
    rd <= 1'b0;
    wr <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || due_q.size() != 0) begin
      if (n > 100) fail_run("outstanding operations did not complete");
      n++;
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      if (proto_err) fail_run("SDRAM model saw an illegal command sequence");
      if (op_begun && !mode_seen) fail_run("request accepted before mode register set");
      expect_eq("rd_pending", rd_pending, inflight > (rd_done ? 1 : 0));
      if (rd_done) begin
        if (exp_q.size() == 0) fail_run("rd_done without an accepted read");
        else expect_eq("rdata", rdata, exp_q.pop_front());
        inflight = inflight - 1;
      end
      if (done) begin
        if (due_q.size() == 0) fail_run("done without an accepted operation");
        else expect_eq("done_cycle", cyc, due_q.pop_front());  // latency and order
      end
      if (op_begun && rd) inflight = inflight + 1;
      cyc <= cyc + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int i;
    int j;
    int n;
    int k;
    rst = 1'b1;
    rd = 1'b0;
    wr = 1'b0;
    addr = '0;
    wdata = '0;
    be = '0;
    seed = SEED;
    for (i = 0; i < NADDR / 2; i++) begin
      seed = xorshift(seed);
      pool_addr[i] = {i[1:0], seed[11:0], seed[14:12], i[4:0]};  // bank, row, col
      pool_addr[i+16] = {i[1:0], seed[11:0], seed[14:12], 5'(i + 16)};  // same row
    end
    repeat (16) @(posedge clk);
    rst  <= 1'b0;
    wr   <= 1'b1;  // a write held through init may only start after the mode set
    addr <= pool_addr[0];

    n = 0;  // power-on wait and init sequence
    while (!mode_seen) begin
      if (n > 30000) fail_run("controller never loaded the mode register");
      if (n < `SDRAM_INIT_CYC) expect_eq("cke", cke, 1'b0);  // clock held off at power-on
      n++;
      @(posedge clk);
    end
    expect_eq("mode_cas", mode_cas, `SDRAM_CAS);
    expect_eq("mode_bl", mode_bl, 0);  // one-word bursts

    for (i = 0; i < NADDR; i++) begin
      seed = xorshift(seed);
      issue(1'b1, i, seed[15:0], 2'b11);
    end
    for (i = 0; i < NADDR; i++) issue(1'b0, i, '0, '0);
    idle_bus();
    drain();

    for (i = 0; i < NADDR; i++) begin  // one lane only
      seed = xorshift(seed);
      issue(1'b1, i, seed[15:0], seed[16] ? 2'b01 : 2'b10);
    end
    for (i = 0; i < NADDR; i++) issue(1'b0, i, '0, '0);
    idle_bus();
    drain();

    for (n = 0; n < NOPS; n++) begin
      seed = xorshift(seed);
      if (seed[0]) begin
        issue(1'b1, seed[5:1], seed[31:16], seed[7:6]);
      end else begin
        k = seed[4:1];
        for (j = 0; j < 2 + seed[6:5]; j++) issue(1'b0, (j % 2) ? k + 16 : k, '0, '0);
      end
    end
    idle_bus();
    drain();

    k = rfsh_cnt;  // refresh keeps running through an idle stretch
    repeat (10 * `SDRAM_REF_CYC) @(posedge clk);
    n = rfsh_cnt - k;
    if (n < 9) fail_run($sformatf("ERR rfsh_cnt rose by 0x%h expected at least 0x9", n));

    if (exp_q.size() != 0 || due_q.size() != 0) begin
      fail_run("operations still outstanding at the end");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- sdram_ctrl.f
+incdir+hw
hw/sdram_pkg.sv
hw/sdram_ifs.sv
hw/sdram_bank_table.sv
hw/sdram_timers.sv
hw/sdram_cmd_fsm.sv
hw/sdram_read_pipe.sv
hw/sdram_ctrl.sv
test/sdram_model.sv
test/sdram_ctrl_checker.sv
test/sdram_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sdram_ctrl_tb \
  -f sdram_ctrl.f -o sdram_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sdram_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^Done: no errors$" sim.log || exit 1
exit 0
